// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mmc3_tb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/mmc3_properties.sv ====
// ####################################################################
// MMC3 mapper assertions on reset, IRQ enable and ROM write refusal
// ####################################################################

`timescale 1ns/1ps

module mmc3_properties import mmc3_pkg::*; (
	input logic      clk,
	input logic      rst_i,
	input cpu_addr_t prg_addr_i,
	input logic      prg_write_i,
	input logic      prg_allow_o,
	input logic      irq_enable,
	input logic      irq_o
);

	int fail_count = 0;                  // Failed assertions so far

	// Low through reset and on the first cycle after it
	irq_low_in_reset: assert property (@(posedge clk) rst_i |=> !irq_o)
		else begin
			$error("irq_o high during or right after reset");
			fail_count++;
		end

	// irq_o only sets on an edge sampled with enable high
	irq_needs_enable: assert property (@(posedge clk) disable iff (rst_i)
		$rose(irq_o) |-> $past(irq_enable))
		else begin
			$error("irq_o rose while irq_enable was low");
			fail_count++;
		end

	rom_write_refused: assert property (@(posedge clk) disable iff (rst_i)
		(prg_write_i && prg_addr_i[15]) |-> !prg_allow_o)
		else begin
			$error("prg_allow_o high for a write to $8000-$FFFF");
			fail_count++;
		end

endmodule

bind mmc3_mapper mmc3_properties u_props (
	.clk         (clk),
	.rst_i       (rst_i),
	.prg_addr_i  (prg_addr_i),
	.prg_write_i (prg_write_i),
	.prg_allow_o (prg_allow_o),
	.irq_enable  (irq_enable),
	.irq_o       (irq_o)
);

// ==== bench/mmc3_stimulus.txt ====
# W addr data care 0 | P addr write exp_addr exp_allow | C ppu_addr exp_addr exp_a10 exp_ce
# S low_cycles ce_steady exp_irq 0 | all fields hex, prg_addr checked only when allowed
P 8123 0 000123 1
P A456 0 000456 1
P C789 0 07C789 1
P FFFF 0 07FFFF 1
P 8000 1 000000 0
W 8000 06 C7 0
W 8001 05 3F 0
W 8000 07 C7 0
W 8001 0A 3F 0
P 8123 0 00A123 1
P A456 0 014456 1
P C789 0 07C789 1
W 8000 46 C7 0
P 8123 0 07C123 1
P A456 0 014456 1
P C789 0 00A789 1
P E000 0 07E000 1
W 8000 00 C7 0
W 8001 10 FE 0
W 8000 01 C7 0
W 8001 24 FE 0
W 8000 02 C7 0
W 8001 30 FF 0
W 8000 03 C7 0
W 8001 31 FF 0
W 8000 04 C7 0
W 8001 42 FF 0
W 8000 05 C7 0
W 8001 57 FF 0
C 0012 204012 0 0
C 0412 204412 0 0
C 0805 209005 1 0
C 0C05 209405 1 0
C 1003 20C003 0 0
C 1403 20C403 0 0
C 1803 210803 1 0
C 1C03 215C03 1 0
W 8000 80 C7 0
C 0003 20C003 0 0
C 0C03 215C03 1 0
C 1012 204012 0 0
C 1C05 209405 1 0
W A000 00 01 0
C 2400 20C400 1 1
C 2800 210800 0 1
W A000 01 01 0
C 2400 20C400 0 1
C 2800 210800 1 1
P 6010 0 000000 0
W A001 80 C0 0
P 6010 0 3C0010 1
P 7FFF 1 3C1FFF 1
W A001 C0 C0 0
P 6010 0 3C0010 1
P 7ABC 1 000000 0
W C000 02 FF 0
W C001 00 00 0
W E001 00 00 0
S 10 1 0 0
S 0E 1 0 0
S 1C 0 0 0
S 10 1 0 0
S 10 1 1 0
S 00 1 1 0
W E000 00 00 0
S 00 1 0 0
S 10 1 0 0
S 10 1 0 0
S 10 1 0 0

// ==== bench/mmc3_tb.sv ====
// ####################################################################
// MMC3 mapper testbench that replays the stimulus file against the DUT
// ####################################################################

`timescale 1ns/1ps

module mmc3_tb import mmc3_pkg::*; ();

	localparam string STIM_FILE = "bench/mmc3_stimulus.txt";

	typedef struct {
		logic [7:0]  kind;                 // W, P, C or S
		int          line_no;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
	} stim_op_t;

	logic      clk;
	logic      rst_i;
	logic      ce_i;
	cpu_addr_t prg_addr_i;
	logic      prg_write_i;
	cpu_data_t prg_data_i;
	ppu_addr_t chr_addr_i;
	logic      chr_is_ram_i;
	mem_addr_t prg_addr_o;
	logic      prg_allow_o;
	mem_addr_t chr_addr_o;
	logic      chr_allow_o;
	logic      vram_a10_o;
	logic      vram_ce_o;
	logic      irq_o;

	stim_op_t  stim_q[$];
	int        errors;
	int        checks;
	int        watchdog_ns;
	logic      watchdog_armed;

	mmc3_mapper dut (
		.clk          (clk),
		.rst_i        (rst_i),
		.ce_i         (ce_i),
		.prg_addr_i   (prg_addr_i),
		.prg_write_i  (prg_write_i),
		.prg_data_i   (prg_data_i),
		.chr_addr_i   (chr_addr_i),
		.chr_is_ram_i (chr_is_ram_i),
		.prg_addr_o   (prg_addr_o),
		.prg_allow_o  (prg_allow_o),
		.chr_addr_o   (chr_addr_o),
		.chr_allow_o  (chr_allow_o),
		.vram_a10_o   (vram_a10_o),
		.vram_ce_o    (vram_ce_o),
		.irq_o        (irq_o)
	);

	always #10 clk = ~clk;               // 20 ns period

	task automatic check_mem_addr(input string name, input mem_addr_t expected,
	                              input mem_addr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s expected %06h actual %06h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic load_stimulus(output bit ok);
		int       fd;
		int       n;
		int       line_no;
		string    line;
		stim_op_t op;
		ok      = 1'b1;
		line_no = 0;
		fd      = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Stimulus file %s could not be opened", STIM_FILE);
			ok = 1'b0;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			line_no++;
			if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r")
				continue;                    // Blank or comment
			n = $sscanf(line, "%c %h %h %h %h", op.kind, op.a, op.b, op.c, op.d);
			if (n != 5 || !(op.kind inside {"W", "P", "C", "S"})) begin
				$display("Stimulus file line %0d is malformed: %s", line_no, line);
				ok = 1'b0;
			end else begin
				op.line_no = line_no;
				stim_q.push_back(op);
			end
		end
		$fclose(fd);
		if (stim_q.size() == 0) begin
			$display("Stimulus file %s holds no operations", STIM_FILE);
			ok = 1'b0;
		end
	endtask

	// Data bits outside care are filled at random
	task automatic write_reg(input cpu_addr_t addr, input cpu_data_t data, input cpu_data_t care);
		cpu_data_t filled;
		filled = (data & care) | (cpu_data_t'($urandom) & ~care);
		@(posedge clk);
		prg_addr_i  <= addr;
		prg_data_i  <= filled;
		prg_write_i <= 1'b1;
		@(posedge clk);                  // DUT samples the write here
		prg_write_i <= 1'b0;
	endtask

	task automatic probe_prg(input cpu_addr_t addr, input logic wr, input mem_addr_t exp_addr,
	                         input logic exp_allow, input string name);
		@(posedge clk);
		prg_addr_i  <= addr;
		prg_write_i <= wr;
		ce_i        <= ~wr;              // Write probes never reach the register port
		@(negedge clk);
		check_bit({name, " prg_allow"}, exp_allow, prg_allow_o);
		if (exp_allow)
			check_mem_addr({name, " prg_addr"}, exp_addr, prg_addr_o); // Don't care if refused
		@(posedge clk);
		prg_write_i <= 1'b0;
		ce_i        <= 1'b1;
	endtask

	task automatic probe_chr(input ppu_addr_t addr, input mem_addr_t exp_addr, input logic exp_a10,
	                         input logic exp_ce, input string name);
		@(posedge clk);
		chr_addr_i   <= addr;
		chr_is_ram_i <= ~chr_is_ram_i;   // Alternate ROM and RAM boards
		@(negedge clk);
		check_mem_addr({name, " chr_addr"}, exp_addr, chr_addr_o);
		check_bit({name, " vram_a10"}, exp_a10, vram_a10_o);
		check_bit({name, " vram_ce"}, exp_ce, vram_ce_o);
		check_bit({name, " chr_allow"}, chr_is_ram_i, chr_allow_o); // Follows the strap
	endtask

	// A12 low for low_cycles clk, then high and left high
	task automatic run_scanline(input int low_cycles, input logic ce_steady, input logic exp_irq,
	                            input string name);
		int i;
		for (i = 0; i < low_cycles; i++) begin
			@(posedge clk);
			chr_addr_i <= 14'h0000;
			ce_i       <= ce_steady | i[0]; // Every other cycle when not steady
		end
		@(posedge clk);
		chr_addr_i <= 14'h1000;
		ce_i       <= 1'b1;
		@(posedge clk);                  // Edge sampled and irq_o updated
		@(negedge clk);
		check_bit({name, " irq"}, exp_irq, irq_o);
	endtask

	initial begin
		bit       loaded;
		stim_op_t op;
		string    name;
		clk            = 1'b0;
		rst_i          = 1'b1;
		ce_i           = 1'b1;
		prg_addr_i     = '0;
		prg_write_i    = 1'b0;
		prg_data_i     = '0;
		chr_addr_i     = '0;
		chr_is_ram_i   = 1'b0;           // Starts as a CHR ROM board
		errors         = 0;
		checks         = 0;
		watchdog_armed = 1'b0;
		void'($urandom(32'hc8e8));
		load_stimulus(loaded);
		if (!loaded) begin
			$display("SOME TESTS FAILED");
		end else begin
			watchdog_ns    = stim_q.size() * 40 * 20;
			watchdog_armed = 1'b1;
			repeat (4) @(posedge clk);
			rst_i <= 1'b0;
			foreach (stim_q[k]) begin
				op   = stim_q[k];
				name = $sformatf("line %0d", op.line_no);
				case (op.kind)
					"W": write_reg(op.a[15:0], op.b[7:0], op.c[7:0]);
					"P": probe_prg(op.a[15:0], op.b[0], op.c[21:0], op.d[0], name);
					"C": probe_chr(op.a[13:0], op.b[21:0], op.c[0], op.d[0], name);
					"S": run_scanline(op.a, op.b[0], op.c[0], name);
					default: ;
				endcase
			end
			repeat (2) @(posedge clk);   // Let the last assertions settle
			errors += dut.u_props.fail_count;
			$display("mmc3_tb: %0d checks, %0d errors (%0d from assertions)",
			         checks, errors, dut.u_props.fail_count);
			if (errors == 0)
				$display("ALL TESTS PASSED");
			else
				$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		wait (watchdog_armed);
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns before all operations finished", watchdog_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== common/mmc3_params.svh ====
// ####################################################################
// MMC3 mapper constants for fixed PRG banks, memory bases and the
// A12 edge filter
// ####################################################################

`ifndef MMC3_PARAMS_SVH
`define MMC3_PARAMS_SVH

// Fixed 8 KB PRG windows
`define MMC3_PRG_LAST_BANK   6'b111111    // Always mapped at $E000
`define MMC3_PRG_SECOND_LAST 6'b111110    // $C000 in mode 0, $8000 in mode 1

// Region bases in the 22 bit cartridge memory map
`define MMC3_PRG_RAM_BASE    9'b111100000 // 8 KB PRG RAM block
`define MMC3_CHR_ROM_BASE    4'b1000      // CHR ROM/RAM block

// Number of ce cycles A12 must stay low before the next rise counts.
// Long enough to ignore the sprite fetch wobble within one scanline.
`define MMC3_A12_FILTER      4'd15

`endif

// ==== common/mmc3_pkg.sv ====
// ####################################################################
// MMC3 mapper types for the CPU and PPU buses, banks and IRQ counter
// ####################################################################

package mmc3_pkg;

	// CPU side
	typedef logic [15:0] cpu_addr_t;     // Full 6502 address
	typedef logic [7:0]  cpu_data_t;     // Data byte on writes

	// PPU side
	typedef logic [13:0] ppu_addr_t;     // 16 KB PPU space

	// Translated address into cartridge ROM/RAM
	typedef logic [21:0] mem_addr_t;     // Up to 4 MB

	// Bank numbers
	typedef logic [5:0]  prg_bank_t;     // 8 KB units, 512 KB max
	typedef logic [7:0]  chr_bank_t;     // 1 KB units, 256 KB max

	// CHR bank registers R0..R5.
	// R0 and R1 select 2 KB pages and hold the bank already halved.
	typedef chr_bank_t [5:0] chr_bank_set_t;

	// Scanline counter and its reload latch
	typedef logic [7:0]  irq_count_t;

endpackage

// ==== hw/mmc3_addr_map.sv ====
// ####################################################################
// MMC3 address translation for PRG ROM, PRG RAM and CHR, plus the
// nametable A10 and CIRAM enable
// ####################################################################

`timescale 1ns/1ps

`include "mmc3_params.svh"

module mmc3_addr_map import mmc3_pkg::*; (
	input  cpu_addr_t     prg_addr_i,
	input  logic          prg_write_i,
	input  ppu_addr_t     chr_addr_i,
	input  logic          chr_is_ram_i,  // Board strap
	input  prg_bank_t     prg_bank0_i,
	input  prg_bank_t     prg_bank1_i,
	input  chr_bank_set_t chr_banks_i,
	input  logic          prg_mode_i,
	input  logic          chr_invert_i,
	input  logic          mirroring_i,
	input  logic          ram_enable_i,
	input  logic          ram_protect_i,
	output mem_addr_t     prg_addr_o,
	output logic          prg_allow_o,
	output mem_addr_t     chr_addr_o,
	output logic          chr_allow_o,
	output logic          vram_a10_o,
	output logic          vram_ce_o
);

	prg_bank_t prg_sel;                  // 8 KB bank for this CPU window
	chr_bank_t chr_sel;                  // 1 KB bank for this PPU window
	logic      prg_is_ram;               // CPU access hits PRG RAM
	logic      chr_half;                 // 1 selects the R2..R5 half

	// PRG window select
	always_comb begin
		case ({prg_addr_i[14:13], prg_mode_i})
			3'b00_0: prg_sel = prg_bank0_i;              // $8000 R6
			3'b00_1: prg_sel = `MMC3_PRG_SECOND_LAST;    // $8000 fixed
			3'b01_0,
			3'b01_1: prg_sel = prg_bank1_i;              // $A000 R7 in both modes
			3'b10_0: prg_sel = `MMC3_PRG_SECOND_LAST;    // $C000 fixed
			3'b10_1: prg_sel = prg_bank0_i;              // $C000 R6
			default: prg_sel = `MMC3_PRG_LAST_BANK;      // $E000 always last
		endcase
	end

	// $6000-$7FFF, writes refused under protect
	assign prg_is_ram = (prg_addr_i[15:13] == 3'b011) && ram_enable_i
	                    && !(ram_protect_i && prg_write_i);

	assign prg_addr_o = prg_is_ram ? {`MMC3_PRG_RAM_BASE, prg_addr_i[12:0]}
	                               : {3'b000, prg_sel, prg_addr_i[12:0]};

	// ROM is read only
	assign prg_allow_o = (prg_addr_i[15] && !prg_write_i) || prg_is_ram;

	// CHR window select
	assign chr_half = chr_addr_i[12] ^ chr_invert_i;

	always_comb begin
		case ({chr_half, chr_addr_i[11:10]})
			3'b0_00,
			3'b0_01: chr_sel = {chr_banks_i[0][6:0], chr_addr_i[10]}; // 2 KB via R0
			3'b0_10,
			3'b0_11: chr_sel = {chr_banks_i[1][6:0], chr_addr_i[10]}; // 2 KB via R1
			3'b1_00: chr_sel = chr_banks_i[2];
			3'b1_01: chr_sel = chr_banks_i[3];
			3'b1_10: chr_sel = chr_banks_i[4];
			default: chr_sel = chr_banks_i[5];
		endcase
	end

	assign chr_addr_o  = {`MMC3_CHR_ROM_BASE, chr_sel, chr_addr_i[9:0]};
	assign chr_allow_o = chr_is_ram_i;   // Writes only reach CHR RAM

	// Nametables
	assign vram_a10_o = mirroring_i ? chr_addr_i[10] : chr_addr_i[11]; // Vertical or horizontal
	assign vram_ce_o  = chr_addr_i[13];  // $2000 and up go to CIRAM

endmodule

// ==== hw/mmc3_mapper.sv ====
// ####################################################################
// MMC3 mapper top, register port, address map and scanline IRQ
// ####################################################################

`timescale 1ns/1ps

module mmc3_mapper import mmc3_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  logic      ce_i,              // CPU M2
	input  cpu_addr_t prg_addr_i,
	input  logic      prg_write_i,
	input  cpu_data_t prg_data_i,
	input  ppu_addr_t chr_addr_i,
	input  logic      chr_is_ram_i,
	output mem_addr_t prg_addr_o,
	output logic      prg_allow_o,
	output mem_addr_t chr_addr_o,
	output logic      chr_allow_o,
	output logic      vram_a10_o,
	output logic      vram_ce_o,
	output logic      irq_o
);

	prg_bank_t     prg_bank0;
	prg_bank_t     prg_bank1;
	chr_bank_set_t chr_banks;
	logic          prg_mode;
	logic          chr_invert;
	logic          mirroring;
	logic          ram_enable;
	logic          ram_protect;
	irq_count_t    irq_latch;
	logic          irq_enable;
	logic          irq_reload;

	mmc3_regs u_regs (
		.clk           (clk),
		.rst_i         (rst_i),
		.ce_i          (ce_i),
		.prg_addr_i    (prg_addr_i),
		.prg_write_i   (prg_write_i),
		.prg_data_i    (prg_data_i),
		.prg_bank0_o   (prg_bank0),
		.prg_bank1_o   (prg_bank1),
		.chr_banks_o   (chr_banks),
		.prg_mode_o    (prg_mode),
		.chr_invert_o  (chr_invert),
		.mirroring_o   (mirroring),
		.ram_enable_o  (ram_enable),
		.ram_protect_o (ram_protect),
		.irq_latch_o   (irq_latch),
		.irq_enable_o  (irq_enable),
		.irq_reload_o  (irq_reload)
	);

	mmc3_addr_map u_addr_map (
		.prg_addr_i    (prg_addr_i),
		.prg_write_i   (prg_write_i),
		.chr_addr_i    (chr_addr_i),
		.chr_is_ram_i  (chr_is_ram_i),
		.prg_bank0_i   (prg_bank0),
		.prg_bank1_i   (prg_bank1),
		.chr_banks_i   (chr_banks),
		.prg_mode_i    (prg_mode),
		.chr_invert_i  (chr_invert),
		.mirroring_i   (mirroring),
		.ram_enable_i  (ram_enable),
		.ram_protect_i (ram_protect),
		.prg_addr_o    (prg_addr_o),
		.prg_allow_o   (prg_allow_o),
		.chr_addr_o    (chr_addr_o),
		.chr_allow_o   (chr_allow_o),
		.vram_a10_o    (vram_a10_o),
		.vram_ce_o     (vram_ce_o)
	);

	mmc3_scanline_irq u_scanline_irq (
		.clk           (clk),
		.rst_i         (rst_i),
		.ce_i          (ce_i),
		.chr_a12_i     (chr_addr_i[12]), // Counter watches raw PPU A12
		.irq_latch_i   (irq_latch),
		.irq_enable_i  (irq_enable),
		.irq_reload_i  (irq_reload),
		.irq_o         (irq_o)
	);

endmodule

// ==== hw/mmc3_regs.sv ====
// ####################################################################
// MMC3 CPU register port, decodes writes to $8000-$FFFF into bank,
// mode, mirroring, PRG RAM and IRQ control registers
// ####################################################################

`timescale 1ns/1ps

module mmc3_regs import mmc3_pkg::*; (
	input  logic          clk,
	input  logic          rst_i,
	input  logic          ce_i,          // M2 strobe
	input  cpu_addr_t     prg_addr_i,
	input  logic          prg_write_i,
	input  cpu_data_t     prg_data_i,
	output prg_bank_t     prg_bank0_o,   // R6
	output prg_bank_t     prg_bank1_o,   // R7
	output chr_bank_set_t chr_banks_o,   // R0..R5
	output logic          prg_mode_o,    // Swaps $8000 and $C000
	output logic          chr_invert_o,  // Swaps the two CHR halves
	output logic          mirroring_o,   // 1 = vertical
	output logic          ram_enable_o,
	output logic          ram_protect_o,
	output irq_count_t    irq_latch_o,
	output logic          irq_enable_o,
	output logic          irq_reload_o   // One clk pulse
);

	logic [2:0] bank_sel;                // Target of next bank data write
	logic       wr_hit;                  // Qualified write into $8000-$FFFF
	logic [2:0] reg_idx;                 // A14, A13, A0

	assign wr_hit  = ce_i & prg_write_i & prg_addr_i[15];
	assign reg_idx = {prg_addr_i[14:13], prg_addr_i[0]};

	always_ff @(posedge clk) begin
		irq_reload_o <= 1'b0;            // Pulse unless set below
		if (rst_i) begin
			bank_sel      <= 3'd0;
			prg_bank0_o   <= '0;
			prg_bank1_o   <= '0;
			chr_banks_o   <= '0;
			prg_mode_o    <= 1'b0;
			chr_invert_o  <= 1'b0;
			mirroring_o   <= 1'b0;
			ram_enable_o  <= 1'b0;
			ram_protect_o <= 1'b0;
			irq_latch_o   <= '0;
			irq_enable_o  <= 1'b0;
		end else if (wr_hit) begin
			case (reg_idx)
				3'b000: begin                               // $8000 bank select
					chr_invert_o <= prg_data_i[7];
					prg_mode_o   <= prg_data_i[6];
					bank_sel     <= prg_data_i[2:0];
				end
				3'b001: begin                               // $8001 bank data
					case (bank_sel)
						3'd0: chr_banks_o[0] <= {1'b0, prg_data_i[7:1]}; // 2 KB page
						3'd1: chr_banks_o[1] <= {1'b0, prg_data_i[7:1]}; // 2 KB page
						3'd2: chr_banks_o[2] <= prg_data_i;
						3'd3: chr_banks_o[3] <= prg_data_i;
						3'd4: chr_banks_o[4] <= prg_data_i;
						3'd5: chr_banks_o[5] <= prg_data_i;
						3'd6: prg_bank0_o    <= prg_data_i[5:0];
						3'd7: prg_bank1_o    <= prg_data_i[5:0];
						default: ;
					endcase
				end
				3'b010: mirroring_o <= ~prg_data_i[0];       // $A000, data 0 is vertical
				3'b011: begin                               // $A001 RAM control
					ram_enable_o  <= prg_data_i[7];
					ram_protect_o <= prg_data_i[6];
				end
				3'b100: irq_latch_o  <= prg_data_i;          // $C000
				3'b101: irq_reload_o <= 1'b1;                // $C001, data ignored
				3'b110: irq_enable_o <= 1'b0;                // $E000 also acks
				3'b111: irq_enable_o <= 1'b1;                // $E001
				default: ;
			endcase
		end
	end

endmodule

// ==== hw/mmc3_scanline_irq.sv ====
// ####################################################################
// MMC3 scanline IRQ, filtered A12 rise clocks an 8 bit down-counter
// ####################################################################

`timescale 1ns/1ps

`include "mmc3_params.svh"

module mmc3_scanline_irq import mmc3_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       ce_i,
	input  logic       chr_a12_i,        // PPU A12
	input  irq_count_t irq_latch_i,
	input  logic       irq_enable_i,
	input  logic       irq_reload_i,     // One clk pulse from $C001
	output logic       irq_o
);

	logic [3:0] filt_cnt;                // Low time since A12 fell
	irq_count_t counter;
	irq_count_t next_count;
	logic       reload_pend;             // Set by $C001 until next edge
	logic       a12_edge;

	assign a12_edge   = ce_i && chr_a12_i && (filt_cnt == 4'd0);
	assign next_count = (counter == '0 || reload_pend) ? irq_latch_i : counter - 8'd1;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			filt_cnt    <= 4'd0;
			counter     <= '0;
			reload_pend <= 1'b0;
			irq_o       <= 1'b0;
		end else begin
			if (ce_i) begin
				if (chr_a12_i)
					filt_cnt <= `MMC3_A12_FILTER;  // Hold off while high
				else if (filt_cnt != 4'd0)
					filt_cnt <= filt_cnt - 4'd1;
			end
			if (a12_edge) begin
				counter     <= next_count;
				reload_pend <= 1'b0;
				if (next_count == '0 && irq_enable_i)
					irq_o <= 1'b1;               // Normal behaviour, fires at zero each time
			end
			// The pulse may land on a low ce cycle, so catch it on any clk
			if (irq_reload_i)
				reload_pend <= 1'b1;
			if (!irq_enable_i)
				irq_o <= 1'b0;                   // Disable acks
		end
	end

endmodule

// ==== vlog.f ====
+incdir+common
common/mmc3_pkg.sv
hw/mmc3_regs.sv
hw/mmc3_addr_map.sv
hw/mmc3_scanline_irq.sv
hw/mmc3_mapper.sv
bench/mmc3_properties.sv
bench/mmc3_tb.sv
